/* mipsExec.f */
+incdir+src
+incdir+dv
src/mipsPkg.sv
src/creditQueue.sv
src/controller.sv
src/alu.sv
src/regFile.sv
src/mipsExec.sv
dv/mipsExecTb.sv

/* run.sh */
#!/usr/bin/env bash
# Compile and run the mipsExec testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --top-module mipsExecTb -f mipsExec.f -o mipsExecSim \
  && ./obj_dir/mipsExecSim > sim.log 2>&1 \
  || echo "Verilator build or simulation returned an error"

cat sim.log 2>/dev/null
grep -qx "RESULT: PASS" sim.log && exit 0 || exit 1

/* dv/mipsModel.svh */
`ifndef MIPS_MODEL_SVH
`define MIPS_MODEL_SVH

`include "mips_params.svh"

logic [31:0] modelRegs [32];  // Register state after every instruction sent so far

function automatic void modelReset();
  for (int i = 0; i < 32; i++) begin
    modelRegs[i] = '0;
  end
endfunction

// Expected record for one instruction, retiring its register write in the model
function automatic mipsPkg::resultT modelExec(input mipsPkg::instrT ins);
  mipsPkg::resultT r;
  logic [5:0]      op;
  logic [5:0]      fn;
  logic [4:0]      rs;
  logic [4:0]      rt;
  logic [4:0]      rd;
  logic [31:0]     a;
  logic [31:0]     b;
  logic [31:0]     sImm;
  logic [31:0]     next;
  op     = ins.word[31:26];
  fn     = ins.word[5:0];
  rs     = ins.word[25:21];
  rt     = ins.word[20:16];
  rd     = ins.word[15:11];
  a      = modelRegs[rs];
  b      = modelRegs[rt];
  sImm   = {{16{ins.word[15]}}, ins.word[15:0]};
  next   = ins.pc + 32'd4;
  r      = '0;
  r.kind = mipsPkg::ALU;
  case (op)
    6'h00: begin
      r.destReg = rd;
      case (fn)
        6'h20: r.value = a + b;
        6'h22: r.value = a - b;
        6'h24: r.value = a & b;
        6'h25: r.value = a | b;
        6'h26: r.value = a ^ b;
        6'h27: r.value = ~(a | b);
        6'h2A: r.value = {31'b0, $signed(a) < $signed(b)};
        6'h18: r.value = a * b;
        6'h00: r.value = b << ins.word[10:6];  // Shift amount from shamt
        6'h02: r.value = b >> ins.word[10:6];
        6'h08: begin
          r.destReg = '0;
          r.kind    = mipsPkg::JUMP;
          r.target  = a;  // jr
        end
        default: begin
          r.destReg = '0;
          r.kind    = mipsPkg::ILLEGAL;
        end
      endcase
    end
    6'h08: begin
      r.destReg = rt;
      r.value   = a + sImm;
    end
    6'h0A: begin
      r.destReg = rt;
      r.value   = {31'b0, $signed(a) < $signed(sImm)};
    end
    6'h0C: begin
      r.destReg = rt;
      r.value   = a & {16'h0, ins.word[15:0]};
    end
    6'h0D: begin
      r.destReg = rt;
      r.value   = a | {16'h0, ins.word[15:0]};
    end
    6'h0E: begin
      r.destReg = rt;
      r.value   = a ^ {16'h0, ins.word[15:0]};
    end
    6'h20, 6'h21, 6'h23: begin
      r.kind    = mipsPkg::LOAD;  // Data comes from memory, so no write here
      r.destReg = rt;
      r.value   = a + sImm;
    end
    6'h28, 6'h29, 6'h2B: begin
      r.kind  = mipsPkg::STORE;
      r.value = a + sImm;
    end
    6'h04, 6'h05, 6'h06, 6'h07: begin
      r.kind   = mipsPkg::BRANCH;
      r.target = next + {sImm[29:0], 2'b00};
      case (op)
        6'h04:   r.taken = (a == b);
        6'h05:   r.taken = (a != b);
        6'h06:   r.taken = ($signed(a) <= 0);
        default: r.taken = ($signed(a) > 0);
      endcase
    end
    6'h01: begin
      r.kind   = mipsPkg::BRANCH;
      r.target = next + {sImm[29:0], 2'b00};
      if (rt == 5'd0) begin
        r.taken = ($signed(a) < 0);
      end else if (rt == 5'd1) begin
        r.taken = ($signed(a) >= 0);
      end else begin
        r      = '0;
        r.kind = mipsPkg::ILLEGAL;
      end
    end
    6'h02: begin
      r.kind   = mipsPkg::JUMP;
      r.target = {next[31:28], ins.word[25:0], 2'b00};
    end
    6'h03: begin
      r.kind    = mipsPkg::LINK;
      r.destReg = 5'(`LINK_REG);
      r.wrote   = 1'b1;
      r.value   = next;
      r.target  = {next[31:28], ins.word[25:0], 2'b00};
    end
    default: r.kind = mipsPkg::ILLEGAL;
  endcase
  if (r.kind == mipsPkg::ALU) begin
    r.wrote = (r.destReg != 5'd0);  // r0 never counts as written
  end
  if (r.wrote) begin
    modelRegs[r.destReg] = r.value;
  end
  return r;
endfunction

`endif

/* dv/mipsExecTb.sv */
`include "mips_params.svh"

module mipsExecTb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_INSTR = 400;
  localparam int TIMEOUT   = NUM_INSTR * 20;

  // add sub and or xor nor slt mul sll srl
  localparam logic [5:0] R_FN [10] = '{6'h20, 6'h22, 6'h24, 6'h25, 6'h26,
                                       6'h27, 6'h2A, 6'h18, 6'h00, 6'h02};
  // ALU immediates then loads and stores
  localparam logic [5:0] I_OP [11] = '{6'h08, 6'h0A, 6'h0C, 6'h0D, 6'h0E,
                                       6'h20, 6'h21, 6'h23, 6'h28, 6'h29, 6'h2B};

  logic            Clk = 1'b0;
  logic            rst;
  logic            inValid;
  mipsPkg::instrT  inInstr;
  logic            inCredit;
  logic            outValid;
  mipsPkg::resultT outResult;
  logic            outCredit;

  integer          seed = 55508;
  int              upCredits;    // Credits upstream may still spend
  int              creditsBack;
  int              held;         // Output credits downstream has not yet returned
  int              dutCredits;   // Output credits the DUT holds this cycle
  int              received;
  int              cycles = 0;
  int              starve;
  mipsPkg::resultT expQ [$];
  logic [31:0]     wordQ [$];

  `include "mipsModel.svh"

  mipsExec i_dut (
    .Clk(Clk), .rst(rst),
    .inValid(inValid), .inInstr(inInstr), .inCredit(inCredit),
    .outValid(outValid), .outResult(outResult), .outCredit(outCredit)
  );

  always #50 Clk = ~Clk;

  function automatic logic [31:0] nextRand();
    return $random(seed);
  endfunction

  function automatic string showResult(input mipsPkg::resultT r);
    return $sformatf("{kind %0d dest %0d wrote %0b value %h taken %0b target %h}",
                     r.kind, r.destReg, r.wrote, r.value, r.taken, r.target);
  endfunction

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic checkResult(input string name, input mipsPkg::resultT expected,
                             input mipsPkg::resultT actual);
    if (expected !== actual) begin
      $display("[ERROR] %s: expected %s actual %s", name, showResult(expected),
               showResult(actual));
      abortRun("Result record does not match the model");
    end
  endtask

  task automatic checkCount(input string name, input int expected, input int actual);
    if (expected != actual) begin
      $display("[ERROR] %s: expected %0d actual %0d", name, expected, actual);
      abortRun("Count does not match");
    end
  endtask

  // Weighted mix with register fields in r0..r7 so values get reused
  function automatic logic [31:0] makeWord();
    logic [31:0] r;
    logic [31:0] f;
    logic [31:0] sel;
    logic [31:0] kk;
    logic [31:0] w;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    int          pick;
    r    = nextRand();
    f    = nextRand();
    sel  = nextRand();
    rs   = {2'b00, r[2:0]};
    rt   = {2'b00, r[5:3]};
    rd   = {2'b00, r[8:6]};
    pick = int'(r[31:16] % 16'd100);
    if (pick < 28) begin
      w = {6'h00, rs, rt, rd, r[13:9], R_FN[int'(sel % 32'd10)]};
    end else if (pick < 58) begin
      w = {I_OP[int'(sel % 32'd11)], rs, rt, f[15:0]};
    end else if (pick < 74) begin
      kk = sel % 32'd6;
      if (kk < 32'd4) begin
        w = {4'b0001, kk[1:0], rs, rt, f[15:0]};  // beq bne blez bgtz
      end else begin
        w = {6'h01, rs, 4'b0000, kk[0], f[15:0]};  // bltz bgez
      end
    end else if (pick < 84) begin
      kk = sel % 32'd3;
      if (kk == 32'd0) begin
        w = {6'h02, f[25:0]};
      end else if (kk == 32'd1) begin
        w = {6'h03, f[25:0]};
      end else begin
        w = {6'h00, rs, 15'h0, 6'h08};
      end
    end else if (pick < 94) begin
      case (sel[1:0])
        2'd0:    w = {6'h0F, rs, rt, f[15:0]};            // Opcode not decoded
        2'd1:    w = {6'h3F, f[25:0]};
        2'd2:    w = {6'h00, rs, rt, rd, 5'h0, 6'h21};    // Unknown funct
        default: w = {6'h01, rs, 1'b1, f[19:16], f[15:0]}; // Unknown REGIMM rt
      endcase
    end else begin
      w = r ^ f;  // Any word at all
    end
    return w;
  endfunction

  // Outputs sampled mid-cycle where they are stable
  always @(negedge Clk) begin
    if (!rst) begin
      if (inCredit) begin
        upCredits++;
        creditsBack++;
      end
      if (outValid) begin
        if (dutCredits == 0) begin
          abortRun("outValid was asserted while the DUT held no output credit");
        end
        if (expQ.size() == 0) begin
          abortRun("A result record arrived with no instruction outstanding");
        end
        checkResult($sformatf("record %0d word %h", received, wordQ.pop_front()),
                    expQ.pop_front(), outResult);
        received++;
        held++;
        dutCredits--;
      end
      if (outCredit) begin
        dutCredits++;
      end
    end
  end

  always @(posedge Clk) begin
    cycles++;
    if (cycles > TIMEOUT) begin
      abortRun($sformatf("Timeout after %0d cycles, %0d of %0d records received",
                         cycles, received, NUM_INSTR));
    end
  end

  initial begin
    int             sent;
    mipsPkg::instrT ins;
    rst         = 1'b1;
    inValid     = 1'b0;
    inInstr     = '0;
    outCredit   = 1'b0;
    upCredits   = `IN_DEPTH;
    held        = `OUT_DEPTH;
    dutCredits  = 0;
    creditsBack = 0;
    received    = 0;
    starve      = 0;
    sent        = 0;
    modelReset();
    repeat (8) @(posedge Clk);
    #5;
    rst = 1'b0;

    while (received < NUM_INSTR) begin
      @(posedge Clk);
      #5;
      inValid   = 1'b0;
      outCredit = 1'b0;
      if (sent < NUM_INSTR && upCredits > 0 && (nextRand() & 32'h7) != 32'h0) begin
        ins.word = makeWord();
        ins.pc   = nextRand() & 32'hFFFF_FFFC;
        inInstr  = ins;
        inValid  = 1'b1;
        upCredits--;
        sent++;
        expQ.push_back(modelExec(ins));
        wordQ.push_back(ins.word);
      end
      // Occasional starvation windows between random credit returns
      if (starve > 0) begin
        starve--;
      end else if ((nextRand() & 32'h1F) == 32'h0) begin
        starve = 10 + int'(nextRand() % 32'd40);
      end else if (held > 0 && (nextRand() & 32'h1) != 32'h0) begin
        outCredit = 1'b1;
        held--;
      end
    end

    @(posedge Clk);
    #5;
    inValid   = 1'b0;
    outCredit = 1'b0;
    repeat (10) @(posedge Clk);  // Catch any extra record

    checkCount("upstream credits returned", NUM_INSTR, creditsBack);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

/* src/mipsExec.sv */
`include "mips_params.svh"

module mipsExec (
  input  logic            Clk,
  input  logic            rst,
  input  logic            inValid,
  input  mipsPkg::instrT  inInstr,
  output logic            inCredit,
  output logic            outValid,
  output mipsPkg::resultT outResult,
  input  logic            outCredit
);

  mipsPkg::instrT       head;
  mipsPkg::ctrlT        ctrl;
  mipsPkg::resultT      res;
  logic                 inEmpty;
  logic                 outEmpty;
  logic                 outFull;
  logic                 pop;
  logic [31:0]          rsData;
  logic [31:0]          rtData;
  logic [31:0]          aluA;
  logic [31:0]          aluB;
  logic [31:0]          aluY;
  logic                 cond;
  logic [31:0]          signImm;
  logic [31:0]          imm;
  logic [31:0]          pcPlus4;
  logic [31:0]          branchTarget;
  logic [31:0]          jumpTarget;
  logic [4:0]           destReg;
  logic [`CREDIT_W-1:0] outCredits;  // Downstream slots we may fill

  creditQueue #(.DEPTH(`IN_DEPTH), .payloadT(mipsPkg::instrT)) inQueue (
    .Clk(Clk), .rst(rst),
    .push(inValid), .pushData(inInstr),
    .pop(pop), .popData(head),
    .empty(inEmpty), .full()
  );

  controller decoder (.instruction(head.word), .ctrl(ctrl));

  regFile regs (
    .Clk(Clk), .rst(rst),
    .rsAddr(head.word[25:21]), .rtAddr(head.word[20:16]),
    .rsData(rsData), .rtData(rtData),
    .we(pop && res.wrote), .wAddr(res.destReg), .wData(res.value)
  );

  assign pcPlus4      = head.pc + 32'd4;
  assign signImm      = {{16{head.word[15]}}, head.word[15:0]};
  assign imm          = ctrl.extZero ? {16'b0, head.word[15:0]} : signImm;
  assign branchTarget = pcPlus4 + {signImm[29:0], 2'b00};
  assign jumpTarget   = {pcPlus4[31:28], head.word[25:0], 2'b00};

  assign aluA = ctrl.useShamt ? {27'b0, head.word[10:6]} : rsData;
  // jal links through PASSB with pc+4 on B
  assign aluB = ctrl.aluSrc ? imm : (ctrl.wbSource == 2'b10) ? pcPlus4 : rtData;

  alu execUnit (.op(ctrl.aluControl), .a(aluA), .b(aluB), .y(aluY), .cond(cond));

  always_comb begin
    case (ctrl.regDstSel)
      2'b01:   destReg = head.word[15:11];
      2'b10:   destReg = 5'(`LINK_REG);
      default: destReg = head.word[20:16];
    endcase
  end

  always_comb begin
    res = '0;
    if (ctrl.illegal) begin
      res.kind = mipsPkg::ILLEGAL;
    end else if (ctrl.memRead) begin
      res.kind    = mipsPkg::LOAD;
      res.destReg = destReg;
      res.value   = aluY;  // Effective address
    end else if (ctrl.memWrite) begin
      res.kind  = mipsPkg::STORE;
      res.value = aluY;
    end else if (ctrl.branch) begin
      res.kind   = mipsPkg::BRANCH;
      res.taken  = cond;
      res.target = branchTarget;
    end else if (ctrl.jump) begin
      res.kind   = ctrl.regWrite ? mipsPkg::LINK : mipsPkg::JUMP;
      res.target = ctrl.jumpReg ? aluY : jumpTarget;
      if (ctrl.regWrite) begin
        res.destReg = destReg;
        res.wrote   = 1'b1;
        res.value   = aluY;
      end
    end else begin
      res.kind    = mipsPkg::ALU;
      res.destReg = destReg;
      res.wrote   = (destReg != 5'd0);
      res.value   = aluY;
    end
  end

  // Retire only when the result has somewhere to go
  assign pop      = !inEmpty && !outFull;
  assign inCredit = pop;

  creditQueue #(.DEPTH(`OUT_DEPTH), .payloadT(mipsPkg::resultT)) outQueue (
    .Clk(Clk), .rst(rst),
    .push(pop), .pushData(res),
    .pop(outValid), .popData(outResult),
    .empty(outEmpty), .full(outFull)
  );

  assign outValid = !outEmpty && (outCredits != '0);

  always_ff @(posedge Clk) begin
    if (rst) begin
      outCredits <= '0;
    end else begin
      outCredits <= outCredits + `CREDIT_W'(outCredit) - `CREDIT_W'(outValid);
    end
  end

endmodule

/* src/regFile.sv */
module regFile (
  input  logic        Clk,
  input  logic        rst,
  input  logic [4:0]  rsAddr,
  input  logic [4:0]  rtAddr,
  output logic [31:0] rsData,
  output logic [31:0] rtData,
  input  logic        we,
  input  logic [4:0]  wAddr,
  input  logic [31:0] wData
);

  logic [31:0] regs [32];

  // Register 0 reads as zero whatever the array holds
  assign rsData = (rsAddr == 5'd0) ? '0 : regs[rsAddr];
  assign rtData = (rtAddr == 5'd0) ? '0 : regs[rtAddr];

  always_ff @(posedge Clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (wAddr != 5'd0)) begin
      regs[wAddr] <= wData;
    end
  end

endmodule

/* src/alu.sv */
module alu (
  input  mipsPkg::aluOpT op,
  input  logic [31:0]    a,
  input  logic [31:0]    b,
  output logic [31:0]    y,
  output logic           cond
);

  logic signed [31:0] sa;
  logic signed [31:0] sb;

  assign sa = $signed(a);
  assign sb = $signed(b);

  always_comb begin
    y    = '0;
    cond = 1'b0;
    case (op)
      mipsPkg::AND:   y = a & b;
      mipsPkg::OR:    y = a | b;
      mipsPkg::XOR:   y = a ^ b;
      mipsPkg::NOR:   y = ~(a | b);
      mipsPkg::ADD:   y = a + b;
      mipsPkg::SUB:   y = a - b;
      mipsPkg::MUL:   y = a * b;  // Low word only
      mipsPkg::SLT:   y = {31'b0, sa < sb};
      mipsPkg::SLL:   y = b << a[4:0];
      mipsPkg::SRL:   y = b >> a[4:0];

      // Branch compares leave y at zero
      mipsPkg::BEQ:   cond = (a == b);
      mipsPkg::BNE:   cond = (a != b);
      mipsPkg::BGTZ:  cond = (sa > 0);
      mipsPkg::BGEZ:  cond = (sa >= 0);
      mipsPkg::BLTZ:  cond = (sa < 0);
      mipsPkg::BLEZ:  cond = (sa <= 0);

      mipsPkg::PASSA: y = a;
      mipsPkg::PASSB: y = b;
      default:        y = '0;
    endcase
  end

endmodule

/* src/controller.sv */
module controller (
  input  logic [31:0]   instruction,
  output mipsPkg::ctrlT ctrl
);

  localparam logic [5:0] OP_RTYPE  = 6'b000000;
  localparam logic [5:0] OP_REGIMM = 6'b000001;
  localparam logic [5:0] OP_J      = 6'b000010;
  localparam logic [5:0] OP_JAL    = 6'b000011;
  localparam logic [5:0] OP_BEQ    = 6'b000100;
  localparam logic [5:0] OP_BNE    = 6'b000101;
  localparam logic [5:0] OP_BLEZ   = 6'b000110;
  localparam logic [5:0] OP_BGTZ   = 6'b000111;
  localparam logic [5:0] OP_ADDI   = 6'b001000;
  localparam logic [5:0] OP_SLTI   = 6'b001010;
  localparam logic [5:0] OP_ANDI   = 6'b001100;
  localparam logic [5:0] OP_ORI    = 6'b001101;
  localparam logic [5:0] OP_XORI   = 6'b001110;
  localparam logic [5:0] OP_LB     = 6'b100000;
  localparam logic [5:0] OP_LH     = 6'b100001;
  localparam logic [5:0] OP_LW     = 6'b100011;
  localparam logic [5:0] OP_SB     = 6'b101000;
  localparam logic [5:0] OP_SH     = 6'b101001;
  localparam logic [5:0] OP_SW     = 6'b101011;

  localparam logic [4:0] RT_BLTZ = 5'b00000;
  localparam logic [4:0] RT_BGEZ = 5'b00001;

  localparam logic [5:0] FN_SLL = 6'b000000;
  localparam logic [5:0] FN_SRL = 6'b000010;
  localparam logic [5:0] FN_JR  = 6'b001000;
  localparam logic [5:0] FN_MUL = 6'b011000;  // Custom multiply
  localparam logic [5:0] FN_ADD = 6'b100000;
  localparam logic [5:0] FN_SUB = 6'b100010;
  localparam logic [5:0] FN_AND = 6'b100100;
  localparam logic [5:0] FN_OR  = 6'b100101;
  localparam logic [5:0] FN_XOR = 6'b100110;
  localparam logic [5:0] FN_NOR = 6'b100111;
  localparam logic [5:0] FN_SLT = 6'b101010;

  logic [5:0] opcode;
  logic [4:0] rt;
  logic [5:0] funct;

  assign opcode = instruction[31:26];
  assign rt     = instruction[20:16];
  assign funct  = instruction[5:0];

  always_comb begin
    ctrl = '0;  // Everything inactive
    ctrl.aluControl = mipsPkg::ADD;
    case (opcode)
      OP_RTYPE: begin
        ctrl.regDstSel = 2'b01;
        ctrl.regWrite  = 1'b1;
        case (funct)
          FN_ADD: ctrl.aluControl = mipsPkg::ADD;
          FN_SUB: ctrl.aluControl = mipsPkg::SUB;
          FN_AND: ctrl.aluControl = mipsPkg::AND;
          FN_OR:  ctrl.aluControl = mipsPkg::OR;
          FN_XOR: ctrl.aluControl = mipsPkg::XOR;
          FN_NOR: ctrl.aluControl = mipsPkg::NOR;
          FN_SLT: ctrl.aluControl = mipsPkg::SLT;
          FN_MUL: ctrl.aluControl = mipsPkg::MUL;
          FN_SLL, FN_SRL: begin
            ctrl.aluControl = (funct == FN_SLL) ? mipsPkg::SLL : mipsPkg::SRL;
            ctrl.useShamt   = 1'b1;
          end
          FN_JR: begin
            ctrl.regWrite   = 1'b0;
            ctrl.jump       = 1'b1;
            ctrl.jumpReg    = 1'b1;
            ctrl.aluControl = mipsPkg::PASSA;
          end
          default: begin
            ctrl.regWrite = 1'b0;
            ctrl.illegal  = 1'b1;
          end
        endcase
      end
      OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.extZero  = (opcode == OP_ANDI) || (opcode == OP_ORI) || (opcode == OP_XORI);
        case (opcode)
          OP_SLTI: ctrl.aluControl = mipsPkg::SLT;
          OP_ANDI: ctrl.aluControl = mipsPkg::AND;
          OP_ORI:  ctrl.aluControl = mipsPkg::OR;
          OP_XORI: ctrl.aluControl = mipsPkg::XOR;
          default: ctrl.aluControl = mipsPkg::ADD;
        endcase
      end
      OP_LW, OP_LH, OP_LB: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memRead  = 1'b1;
        ctrl.wbSource = 2'b01;
        ctrl.regWrite = 1'b1;  // Data arrives from memory, outside
      end
      OP_SW, OP_SH, OP_SB: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memWrite = 1'b1;
      end
      OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: begin
        ctrl.branch = 1'b1;
        case (opcode)
          OP_BEQ:  ctrl.aluControl = mipsPkg::BEQ;
          OP_BNE:  ctrl.aluControl = mipsPkg::BNE;
          OP_BLEZ: ctrl.aluControl = mipsPkg::BLEZ;
          default: ctrl.aluControl = mipsPkg::BGTZ;
        endcase
      end
      OP_REGIMM: begin
        // bltz and bgez picked by the rt field
        ctrl.branch = 1'b1;
        case (rt)
          RT_BLTZ: ctrl.aluControl = mipsPkg::BLTZ;
          RT_BGEZ: ctrl.aluControl = mipsPkg::BGEZ;
          default: begin
            ctrl.branch  = 1'b0;
            ctrl.illegal = 1'b1;
          end
        endcase
      end
      OP_J: ctrl.jump = 1'b1;
      OP_JAL: begin
        ctrl.jump       = 1'b1;
        ctrl.regWrite   = 1'b1;
        ctrl.regDstSel  = 2'b10;
        ctrl.wbSource   = 2'b10;
        ctrl.aluControl = mipsPkg::PASSB;
      end
      default: ctrl.illegal = 1'b1;  // Unknown opcode
    endcase
  end

endmodule

/* src/creditQueue.sv */
module creditQueue #(
  parameter int  DEPTH    = 4,
  parameter type payloadT = logic [31:0]
) (
  input  logic    Clk,
  input  logic    rst,
  input  logic    push,
  input  payloadT pushData,
  input  logic    pop,
  output payloadT popData,
  output logic    empty,
  output logic    full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payloadT          mem [DEPTH];
  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W-1:0] rdPtr;
  logic [CNT_W-1:0] count;  // Occupancy, one per credit spent by the sender
  logic             doPush;
  logic             doPop;

  assign doPush  = push && !full;
  assign doPop   = pop && !empty;
  assign empty   = (count == '0);
  assign full    = (count == CNT_W'(DEPTH));
  assign popData = mem[rdPtr];  // Head visible the cycle after its push

  always_ff @(posedge Clk) begin
    if (doPush) begin
      mem[wrPtr] <= pushData;
    end
  end

  always_ff @(posedge Clk) begin
    if (rst) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) begin
        wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (doPop) begin
        rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
      end
      count <= count + CNT_W'(doPush) - CNT_W'(doPop);
    end
  end

endmodule

/* src/mipsPkg.sv */
package mipsPkg;

  // ALU operation codes, same numbering as the ALUControl map
  typedef enum logic [5:0] {
    AND   = 6'd0,
    OR    = 6'd1,
    XOR   = 6'd2,
    NOR   = 6'd3,
    ADD   = 6'd4,
    SUB   = 6'd5,
    MUL   = 6'd6,
    SLT   = 6'd7,
    SLL   = 6'd8,
    SRL   = 6'd9,
    BEQ   = 6'd10,
    BNE   = 6'd11,
    BGTZ  = 6'd12,
    BGEZ  = 6'd13,
    BLTZ  = 6'd14,
    BLEZ  = 6'd15,
    PASSA = 6'd16,  // jr
    PASSB = 6'd17   // jal
  } aluOpT;

  typedef struct packed {
    logic [31:0] word;
    logic [31:0] pc;
  } instrT;

  typedef struct packed {
    logic       aluSrc;      // B from immediate
    logic [1:0] regDstSel;   // 00 rt, 01 rd, 10 link register
    aluOpT      aluControl;
    logic       memRead;
    logic       memWrite;
    logic [1:0] wbSource;    // 00 ALU, 01 memory, 10 pc+4
    logic       regWrite;
    logic       branch;
    logic       jump;
    logic       jumpReg;
    logic       extZero;     // Zero-extend the immediate
    logic       useShamt;    // A from shamt
    logic       illegal;
  } ctrlT;

  typedef enum logic [2:0] {
    ALU,
    LOAD,
    STORE,
    BRANCH,
    JUMP,
    LINK,
    ILLEGAL
  } resKindT;

  typedef struct packed {
    resKindT     kind;
    logic [4:0]  destReg;
    logic        wrote;
    logic [31:0] value;
    logic        taken;
    logic [31:0] target;
  } resultT;

endpackage

/* src/mips_params.svh */
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// Input queue depth, also the credits upstream holds after reset
`define IN_DEPTH 4

// Output queue depth
`define OUT_DEPTH 4

// Wide enough to count every credit of either queue
`define CREDIT_W 3

`define LINK_REG 31  // Written by jal

`endif
